// File: design/missunit_settings.svh
// geometry of the write-through L1 data cache miss handler
// the last miss port is the write port; all other ports only read
// a line is 2**MU_OFFSET_W bytes, the tag takes the remaining address bits
`ifndef MISSUNIT_SETTINGS_SVH
`define MISSUNIT_SETTINGS_SVH

// miss ports, the highest one issues writes
`define MU_NUM_PORTS 3
// associativity
`define MU_WAYS 4

// physical address split
`define MU_ADDR_W 32
`define MU_OFFSET_W 4
`define MU_INDEX_W 6

// memory transaction id width
`define MU_TID_W 2
// stores allowed in flight before new stores stall
`define MU_MAX_STORES 4

// non-zero start value of the replacement LFSR
`define MU_LFSR_SEED 8'hA5

`endif

// File: design/missunit_pkg.sv
// types and helpers shared by the miss handler and its testbench
// widths come from the settings header
`default_nettype none

`include "missunit_settings.svh"

package missunit_pkg;

  typedef logic [`MU_ADDR_W-1:0] paddr_t;
  typedef logic [`MU_ADDR_W-`MU_INDEX_W-`MU_OFFSET_W-1:0] tag_t;
  typedef logic [`MU_INDEX_W-1:0] idx_t;
  typedef logic [$clog2(`MU_WAYS)-1:0] way_t;
  typedef logic [`MU_WAYS-1:0] way_vec_t;
  typedef logic [`MU_TID_W-1:0] tid_t;
  typedef logic [$clog2(`MU_NUM_PORTS)-1:0] port_idx_t;
  typedef logic [`MU_NUM_PORTS-1:0] port_vec_t;
  typedef logic [8*(1<<`MU_OFFSET_W)-1:0] line_t;
  typedef logic [63:0] word_t;
  // log2 of the access size in bytes
  typedef logic [2:0] size_t;

  typedef enum logic {LOAD_REQ, STORE_REQ} mem_req_e;
  typedef enum logic {LOAD_ACK, STORE_ACK} mem_rtrn_e;
  typedef enum logic [2:0] {IDLE, DRAIN, FLUSH, STORE_WAIT, LOAD_WAIT} ctrl_state_e;

  // one miss as raised by a cache port
  typedef struct packed {
    paddr_t   paddr;
    logic     we;
    logic     nc;
    size_t    size;
    tid_t     id;
    word_t    wdata;
    way_vec_t vld_bits;
  } miss_req_t;

  typedef struct packed {
    mem_req_e rtype;
    tid_t     tid;
    logic     nc;
    way_t     way;
    paddr_t   paddr;
    size_t    size;
    word_t    data;
  } mem_req_t;

  typedef struct packed {
    mem_rtrn_e rtype;
    tid_t      tid;
    line_t     data;
  } mem_rtrn_t;

  // cacheline write port towards tag and data memories
  typedef struct packed {
    logic                     vld;
    logic                     nc;
    way_vec_t                 we;
    way_vec_t                 vld_bits;
    tag_t                     tag;
    idx_t                     idx;
    line_t                    data;
    logic [$bits(line_t)/8-1:0] be;
  } cl_wr_t;

  typedef struct packed {
    paddr_t    paddr;
    size_t     size;
    tid_t      id;
    logic      nc;
    way_t      way;
    port_idx_t port;
  } mshr_t;

  // clear the address bits below the access size
  function automatic paddr_t paddr_align(paddr_t paddr, size_t size);
    paddr_t mask;
    mask = ~((paddr_t'(1) << size) - paddr_t'(1));
    return paddr & mask;
  endfunction

  function automatic way_vec_t way_bin2oh(way_t way);
    way_vec_t oh;
    oh      = '0;
    oh[way] = 1'b1;
    return oh;
  endfunction

  // line address, offset bits shifted out
  function automatic paddr_t line_addr(paddr_t paddr);
    return paddr >> `MU_OFFSET_W;
  endfunction

endpackage

`default_nettype wire

// File: design/miss_port_arbiter.sv
// fixed priority miss arbiter, port 0 wins
// the masked request vector is registered so it can be frozen while waiting for memory
`timescale 1ns/100ps
`default_nettype none

module miss_port_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  missunit_pkg::port_vec_t   miss_valid_i,
  input  missunit_pkg::port_vec_t   miss_we_i,
  input  logic                      mask_reads_i,
  input  logic                      lock_reqs_i,
  output missunit_pkg::port_idx_t   sel_port_o,
  output logic                      any_req_o
);

  missunit_pkg::port_vec_t masked_d, masked_q;

  // lock keeps the vector of the pending request, mask lets only writes through
  assign masked_d = lock_reqs_i  ? masked_q :
                    mask_reads_i ? (miss_valid_i & miss_we_i) :
                                   miss_valid_i;

  assign any_req_o = |masked_d;

  // lowest set bit wins
  always_comb begin : p_pick
    sel_port_o = '0;
    for (int k = $bits(missunit_pkg::port_vec_t) - 1; k >= 0; k--) begin
      if (masked_d[k]) begin
        sel_port_o = missunit_pkg::port_idx_t'(k);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      masked_q <= '0;
    end else begin
      masked_q <= masked_d;
    end
  end

endmodule

`default_nettype wire

// File: design/refill_way_select.sv
// refill way choice: first invalid way, else a pseudo random way
// the LFSR only moves when a step hits a full set
`timescale 1ns/100ps
`default_nettype none

`include "missunit_settings.svh"

module refill_way_select (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  missunit_pkg::way_vec_t   vld_bits_i,
  input  logic                     step_i,
  output missunit_pkg::way_t       way_o
);

  logic [7:0]         lfsr_q;
  logic               lfsr_fb;
  logic               all_valid;
  missunit_pkg::way_t inv_way;

  assign all_valid = &vld_bits_i;

  // lowest invalid way
  always_comb begin : p_inv_way
    inv_way = '0;
    for (int k = `MU_WAYS - 1; k >= 0; k--) begin
      if (!vld_bits_i[k]) begin
        inv_way = missunit_pkg::way_t'(k);
      end
    end
  end

  assign way_o = all_valid ? lfsr_q[$bits(missunit_pkg::way_t)-1:0] : inv_way;

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q <= `MU_LFSR_SEED;
    end else if (step_i && all_valid) begin
      // advance only after an eviction, so the next full set sees a new way
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

endmodule

`default_nettype wire

// File: design/miss_mshr.sv
// single read MSHR, store counter and line collision checks
// only one read is outstanding, so every accepted LOAD_ACK frees the entry
`timescale 1ns/100ps
`default_nettype none

`include "missunit_settings.svh"

module miss_mshr (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        alloc_i,
  input  missunit_pkg::miss_req_t     req_i,
  input  missunit_pkg::port_idx_t     port_i,
  input  missunit_pkg::way_t          way_i,
  input  logic                        load_ack_i,
  input  logic                        store_ack_i,
  input  logic                        store_sent_i,
  input  missunit_pkg::port_vec_t     miss_valid_i,
  input  missunit_pkg::paddr_t        miss_paddr_i [`MU_NUM_PORTS],
  output missunit_pkg::mshr_t         mshr_o,
  output logic                        mshr_vld_o,
  output logic                        wr_coll_o,
  output missunit_pkg::port_vec_t     replay_o,
  output logic                        store_room_o,
  output logic                        store_pend_o
);

  missunit_pkg::mshr_t     mshr_q;
  logic                    vld_q, vld_q1;
  missunit_pkg::port_vec_t rdrd_hit, rdrd_coll_d, rdrd_coll_q;
  logic [$clog2(`MU_MAX_STORES+1)-1:0] stores_q;

  assign mshr_o     = mshr_q;
  assign mshr_vld_o = vld_q;

  // read/read collision, the delayed valid also covers the refill cycle itself
  // the bit sticks until the port drops its request
  for (genvar k = 0; k < `MU_NUM_PORTS; k++) begin : gen_rdrd
    assign rdrd_hit[k] = (missunit_pkg::line_addr(mshr_q.paddr) ==
                          missunit_pkg::line_addr(miss_paddr_i[k])) && (vld_q || vld_q1);
    assign rdrd_coll_d[k] = miss_valid_i[k] && (rdrd_coll_q[k] || rdrd_hit[k]);
  end
  assign replay_o = rdrd_coll_d;

  // write to the line being refilled must wait
  assign wr_coll_o = (missunit_pkg::line_addr(mshr_q.paddr) ==
                      missunit_pkg::line_addr(miss_paddr_i[`MU_NUM_PORTS-1])) && vld_q;

  assign store_room_o = (stores_q < `MU_MAX_STORES);
  assign store_pend_o = (stores_q != '0);

  always_ff @(posedge clk_i) begin : p_payload
    if (alloc_i) begin
      mshr_q.paddr <= req_i.paddr;
      mshr_q.size  <= req_i.size;
      mshr_q.id    <= req_i.id;
      mshr_q.nc    <= req_i.nc;
      mshr_q.way   <= way_i;
      mshr_q.port  <= port_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      vld_q       <= 1'b0;
      vld_q1      <= 1'b0;
      rdrd_coll_q <= '0;
      stores_q    <= '0;
    end else begin
      // allocation wins, a load ack in the same cycle frees the old entry
      if (alloc_i) begin
        vld_q <= 1'b1;
      end else if (load_ack_i) begin
        vld_q <= 1'b0;
      end
      vld_q1      <= vld_q;
      rdrd_coll_q <= rdrd_coll_d;
      if (store_sent_i && !store_ack_i) begin
        stores_q <= stores_q + 1'b1;
      end else if (store_ack_i && !store_sent_i) begin
        stores_q <= stores_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/miss_ctrl_fsm.sv
// controller of the miss handler with invalidation sweep, drain, issue and wait states
// comes out of reset in FLUSH and sweeps every index before taking misses
// enabling the cache always goes through a flush while disabling is immediate
`timescale 1ns/100ps
`default_nettype none

module miss_ctrl_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic                       flush_i,
  input  logic                       wbuffer_empty_i,
  input  logic                       any_req_i,
  input  logic                       is_write_i,
  input  logic                       req_nc_i,
  input  logic                       mshr_vld_i,
  input  logic                       wr_coll_i,
  input  logic                       replay_i,
  input  logic                       store_room_i,
  input  logic                       load_ack_i,
  input  logic                       mem_ack_i,
  output logic                       mem_valid_o,
  output missunit_pkg::mem_req_e     rtype_o,
  output logic                       mshr_alloc_o,
  output logic                       lfsr_step_o,
  output logic                       mask_reads_o,
  output logic                       lock_reqs_o,
  output logic                       replay_o,
  output logic                       flush_en_o,
  output missunit_pkg::idx_t         flush_idx_o,
  output logic                       flush_ack_o,
  output logic                       cache_en_o,
  output logic                       miss_o
);

  missunit_pkg::ctrl_state_e state_d, state_q;
  missunit_pkg::idx_t        cnt_q;
  logic                      enable_d, enable_q;
  logic                      flush_ack_d, flush_ack_q;
  logic                      idle_ok;

  // nothing left in flight
  assign idle_ok     = wbuffer_empty_i && !mshr_vld_i;
  assign flush_idx_o = cnt_q;
  assign cache_en_o  = enable_q;
  // the way selector ignores steps while a free way exists
  assign lfsr_step_o = mshr_alloc_o;
  assign miss_o      = mshr_alloc_o && !req_nc_i;

  always_comb begin : p_fsm
    state_d      = state_q;
    enable_d     = enable_q && enable_i;
    flush_ack_d  = flush_ack_q;
    flush_ack_o  = 1'b0;
    flush_en_o   = 1'b0;
    mem_valid_o  = 1'b0;
    rtype_o      = missunit_pkg::LOAD_REQ;
    mshr_alloc_o = 1'b0;
    replay_o     = 1'b0;
    lock_reqs_o  = 1'b0;
    mask_reads_o = mshr_vld_i;

    unique case (state_q)
      ////////////////////////////////////////////////
      missunit_pkg::IDLE: begin
        if (flush_i || (enable_i && !enable_q)) begin
          // only a flush request is answered at the end of the sweep
          flush_ack_d = flush_i;
          if (idle_ok) begin
            state_d = missunit_pkg::FLUSH;
          end else begin
            state_d = missunit_pkg::DRAIN;
          end
        end else if (any_req_i) begin
          if (is_write_i) begin
            // store passes through unless it hits the refill line or the counter is full
            if (!wr_coll_i && store_room_i) begin
              mem_valid_o = 1'b1;
              rtype_o     = missunit_pkg::STORE_REQ;
              if (!mem_ack_i) begin
                state_d = missunit_pkg::STORE_WAIT;
              end
            end
          end else if (!mshr_vld_i || load_ack_i) begin
            // line may have been refilled while this read waited
            if (replay_i) begin
              replay_o = 1'b1;
            end else begin
              mem_valid_o  = 1'b1;
              mshr_alloc_o = mem_ack_i;
              if (!mem_ack_i) begin
                state_d = missunit_pkg::LOAD_WAIT;
              end
            end
          end
        end
      end
      ////////////////////////////////////////////////
      missunit_pkg::STORE_WAIT: begin
        lock_reqs_o = 1'b1;
        mem_valid_o = 1'b1;
        rtype_o     = missunit_pkg::STORE_REQ;
        if (mem_ack_i) begin
          state_d = missunit_pkg::IDLE;
        end
      end
      missunit_pkg::LOAD_WAIT: begin
        lock_reqs_o = 1'b1;
        mem_valid_o = 1'b1;
        if (mem_ack_i) begin
          mshr_alloc_o = 1'b1;
          state_d      = missunit_pkg::IDLE;
        end
      end
      ////////////////////////////////////////////////
      missunit_pkg::DRAIN: begin
        // only writes pass while reads stay parked until the flush is done
        mask_reads_o = 1'b1;
        flush_ack_d  = flush_ack_q || flush_i;
        if (any_req_i && !wr_coll_i && store_room_i) begin
          mem_valid_o = 1'b1;
          rtype_o     = missunit_pkg::STORE_REQ;
        end
        if (idle_ok) begin
          state_d = missunit_pkg::FLUSH;
        end
      end
      missunit_pkg::FLUSH: begin
        flush_en_o = 1'b1;
        if (&cnt_q) begin
          flush_ack_o = flush_ack_q;
          flush_ack_d = 1'b0;
          enable_d    = enable_i;
          state_d     = missunit_pkg::IDLE;
        end
      end
      default: begin
        state_d = missunit_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= missunit_pkg::FLUSH;
      cnt_q       <= '0;
      enable_q    <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // sweep index returns to zero outside FLUSH
      cnt_q       <= flush_en_o ? cnt_q + 1'b1 : '0;
      enable_q    <= enable_d;
      flush_ack_q <= flush_ack_d;
    end
  end

endmodule

`default_nettype wire

// File: design/refill_write_port.sv
// memory response decode and cacheline write port
// responses that match no pending transaction are dropped
// only complete lines are written, never partial refills
`timescale 1ns/100ps
`default_nettype none

`include "missunit_settings.svh"

module refill_write_port (
  input  logic                       mem_rtrn_vld_i,
  input  missunit_pkg::mem_rtrn_t    mem_rtrn_i,
  input  missunit_pkg::mshr_t        mshr_i,
  input  logic                       mshr_vld_i,
  input  logic                       store_pend_i,
  input  logic                       flush_en_i,
  input  missunit_pkg::idx_t         flush_idx_i,
  output logic                       load_ack_o,
  output logic                       store_ack_o,
  output missunit_pkg::port_vec_t    rtrn_vld_o,
  output missunit_pkg::tid_t         rtrn_id_o,
  output missunit_pkg::cl_wr_t       cl_wr_o
);

  logic                   cl_write_en;
  missunit_pkg::way_vec_t refill_oh;

  always_comb begin : p_rtrn
    load_ack_o  = 1'b0;
    store_ack_o = 1'b0;
    rtrn_vld_o  = '0;
    if (mem_rtrn_vld_i) begin
      case (mem_rtrn_i.rtype)
        missunit_pkg::LOAD_ACK: begin
          if (mshr_vld_i) begin
            load_ack_o               = 1'b1;
            rtrn_vld_o[mshr_i.port]  = 1'b1;
          end
        end
        missunit_pkg::STORE_ACK: begin
          // store acks always belong to the write port
          if (store_pend_i) begin
            store_ack_o                    = 1'b1;
            rtrn_vld_o[`MU_NUM_PORTS-1]    = 1'b1;
          end
        end
      endcase
    end
  end

  // write buffer matches store acks by id
  assign rtrn_id_o = mem_rtrn_i.tid;

  // nc loads go to the port only
  assign cl_write_en = load_ack_o && !mshr_i.nc;
  assign refill_oh   = missunit_pkg::way_bin2oh(mshr_i.way);

  ////////////////////////////////////////////////
  // sweep clears all ways of one index per cycle
  assign cl_wr_o.we       = flush_en_i  ? '1 :
                            cl_write_en ? refill_oh : '0;
  assign cl_wr_o.vld_bits = (cl_write_en && !flush_en_i) ? refill_oh : '0;
  assign cl_wr_o.vld      = load_ack_o || (|cl_wr_o.we);
  assign cl_wr_o.nc       = mshr_i.nc;
  assign cl_wr_o.idx      = flush_en_i ? flush_idx_i :
                            mshr_i.paddr[`MU_OFFSET_W +: `MU_INDEX_W];
  assign cl_wr_o.tag      = mshr_i.paddr[`MU_OFFSET_W+`MU_INDEX_W +: $bits(missunit_pkg::tag_t)];
  assign cl_wr_o.data     = mem_rtrn_i.data;
  assign cl_wr_o.be       = cl_write_en ? '1 : '0;

endmodule

`default_nettype wire

// File: design/dcache_missunit.sv
// miss handler of the write-through L1 data cache
// ports below the last one must only raise reads, the last only writes
// mem_req_o is valid only with mem_valid_o and holds until mem_ack_i
`timescale 1ns/100ps
`default_nettype none

`include "missunit_settings.svh"

module dcache_missunit (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             enable_i,
  input  logic                                             flush_i,
  input  logic                                             wbuffer_empty_i,
  output logic                                             flush_ack_o,
  output logic                                             cache_en_o,
  output logic                                             miss_o,
  // cache side miss ports
  input  missunit_pkg::miss_req_t [`MU_NUM_PORTS-1:0]      miss_req_i,
  input  missunit_pkg::port_vec_t                          miss_valid_i,
  output missunit_pkg::port_vec_t                          miss_ack_o,
  output missunit_pkg::port_vec_t                          miss_replay_o,
  output missunit_pkg::port_vec_t                          miss_rtrn_vld_o,
  output missunit_pkg::tid_t                               miss_rtrn_id_o,
  // memory side
  output missunit_pkg::mem_req_t                           mem_req_o,
  output logic                                             mem_valid_o,
  input  logic                                             mem_ack_i,
  input  missunit_pkg::mem_rtrn_t                          mem_rtrn_i,
  input  logic                                             mem_rtrn_vld_i,
  output missunit_pkg::cl_wr_t                             cl_wr_o
);

  missunit_pkg::port_vec_t   miss_we, mshr_replay;
  missunit_pkg::paddr_t      miss_paddr [`MU_NUM_PORTS];
  missunit_pkg::port_idx_t   sel_port;
  missunit_pkg::miss_req_t   sel_req;
  missunit_pkg::way_t        refill_way;
  missunit_pkg::mshr_t       mshr;
  missunit_pkg::mem_req_e    rtype;
  missunit_pkg::idx_t        flush_idx;
  logic any_req, mask_reads, lock_reqs, mshr_alloc, lfsr_step, flush_en, fsm_replay;
  logic mshr_vld, wr_coll, store_room, store_pend, store_sent, load_ack, store_ack;

  for (genvar k = 0; k < `MU_NUM_PORTS; k++) begin : gen_unpack
    assign miss_we[k]    = miss_req_i[k].we;
    assign miss_paddr[k] = miss_req_i[k].paddr;
  end

  assign sel_req    = miss_req_i[sel_port];
  assign store_sent = mem_valid_o && mem_ack_i && (rtype == missunit_pkg::STORE_REQ);

  ////////////////////////////////////////////////
  // request mux, stores never carry a way
  assign mem_req_o.rtype = rtype;
  assign mem_req_o.tid   = sel_req.id;
  assign mem_req_o.nc    = sel_req.nc;
  assign mem_req_o.way   = (rtype == missunit_pkg::LOAD_REQ) ? refill_way : '0;
  assign mem_req_o.paddr = missunit_pkg::paddr_align(sel_req.paddr, sel_req.size);
  assign mem_req_o.size  = sel_req.size;
  assign mem_req_o.data  = sel_req.wdata;

  always_comb begin : p_port_strobes
    miss_ack_o              = '0;
    miss_replay_o           = '0;
    miss_ack_o[sel_port]    = mem_ack_i && mem_valid_o;
    miss_replay_o[sel_port] = fsm_replay;
  end

  miss_port_arbiter u_arb (
    .clk_i, .rst_ni,
    .miss_valid_i, .miss_we_i(miss_we), .mask_reads_i(mask_reads),
    .lock_reqs_i(lock_reqs), .sel_port_o(sel_port), .any_req_o(any_req)
  );

  refill_way_select u_way (
    .clk_i, .rst_ni,
    .vld_bits_i(sel_req.vld_bits), .step_i(lfsr_step), .way_o(refill_way)
  );

  miss_mshr u_mshr (
    .clk_i, .rst_ni,
    .alloc_i(mshr_alloc), .req_i(sel_req), .port_i(sel_port), .way_i(refill_way),
    .load_ack_i(load_ack), .store_ack_i(store_ack), .store_sent_i(store_sent),
    .miss_valid_i, .miss_paddr_i(miss_paddr), .mshr_o(mshr), .mshr_vld_o(mshr_vld),
    .wr_coll_o(wr_coll), .replay_o(mshr_replay), .store_room_o(store_room),
    .store_pend_o(store_pend)
  );

  miss_ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .enable_i, .flush_i, .wbuffer_empty_i,
    .any_req_i(any_req), .is_write_i(sel_req.we), .req_nc_i(sel_req.nc),
    .mshr_vld_i(mshr_vld), .wr_coll_i(wr_coll), .replay_i(mshr_replay[sel_port]),
    .store_room_i(store_room), .load_ack_i(load_ack), .mem_ack_i,
    .mem_valid_o, .rtype_o(rtype), .mshr_alloc_o(mshr_alloc), .lfsr_step_o(lfsr_step),
    .mask_reads_o(mask_reads), .lock_reqs_o(lock_reqs), .replay_o(fsm_replay),
    .flush_en_o(flush_en), .flush_idx_o(flush_idx), .flush_ack_o, .cache_en_o, .miss_o
  );

  refill_write_port u_wr (
    .mem_rtrn_vld_i, .mem_rtrn_i, .mshr_i(mshr), .mshr_vld_i(mshr_vld),
    .store_pend_i(store_pend), .flush_en_i(flush_en), .flush_idx_i(flush_idx),
    .load_ack_o(load_ack), .store_ack_o(store_ack), .rtrn_vld_o(miss_rtrn_vld_o),
    .rtrn_id_o(miss_rtrn_id_o), .cl_wr_o
  );

endmodule

`default_nettype wire

// File: test/tb_dcache_missunit.sv
// directed testbench of the miss handler, one port and one memory model in sequence
// vld_bits of every read keep one way free, so the LFSR way is never expected
// every wait is bounded, a timeout counts as an error
`timescale 1ns/100ps
`default_nettype none

`include "missunit_settings.svh"

module tb_dcache_missunit;

  localparam int WaitMax  = 50;
  localparam int SweepMax = 200;

  logic clk_i = 1'b0;
  logic rst_ni, enable_i, flush_i, wbuffer_empty_i, mem_ack_i, mem_rtrn_vld_i;
  logic flush_ack_o, cache_en_o, miss_o, mem_valid_o;
  missunit_pkg::miss_req_t [`MU_NUM_PORTS-1:0] miss_req_i;
  missunit_pkg::port_vec_t miss_valid_i, miss_ack_o, miss_replay_o, miss_rtrn_vld_o;
  missunit_pkg::tid_t      miss_rtrn_id_o;
  missunit_pkg::mem_req_t  mem_req_o;
  missunit_pkg::mem_rtrn_t mem_rtrn_i;
  missunit_pkg::cl_wr_t    cl_wr_o;

  int seed;
  int errors;
  int tests;

  dcache_missunit UUT (.*);

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // reference model of one miss
  function automatic void ref_refill(input missunit_pkg::miss_req_t m,
                                     input missunit_pkg::line_t rdata,
                                     output missunit_pkg::mem_req_t mr,
                                     output missunit_pkg::cl_wr_t cw);
    missunit_pkg::way_t     w;
    missunit_pkg::way_vec_t oh;
    missunit_pkg::paddr_t   aligned;
    w  = '0;
    oh = '0;
    // lowest invalid way
    for (int k = `MU_WAYS - 1; k >= 0; k--) begin
      if (!m.vld_bits[k]) w = missunit_pkg::way_t'(k);
    end
    for (int k = 0; k < `MU_ADDR_W; k++) begin
      aligned[k] = (k < int'(m.size)) ? 1'b0 : m.paddr[k];
    end
    if (!m.we && !m.nc) oh[w] = 1'b1;
    mr.rtype = m.we ? missunit_pkg::STORE_REQ : missunit_pkg::LOAD_REQ;
    mr.tid   = m.id;
    mr.nc    = m.nc;
    mr.way   = m.we ? '0 : w;
    mr.paddr = aligned;
    mr.size  = m.size;
    mr.data  = m.wdata;
    // nc loads are reported but write no way
    cw.vld      = 1'b1;
    cw.nc       = m.nc;
    cw.we       = oh;
    cw.vld_bits = oh;
    cw.tag      = m.paddr[`MU_OFFSET_W+`MU_INDEX_W +: $bits(missunit_pkg::tag_t)];
    cw.idx      = m.paddr[`MU_OFFSET_W +: `MU_INDEX_W];
    cw.data     = rdata;
    cw.be       = m.nc ? '0 : '1;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  task automatic check_mem_req(input missunit_pkg::mem_req_t exp, got);
    if (got !== exp) begin
      $display("** Error: mem_req_o expected %h got %h", exp, got);
      errors++;
    end
  endtask

  task automatic check_cl_wr(input missunit_pkg::cl_wr_t exp, got);
    if (got !== exp) begin
      $display("** Error: cl_wr_o expected %h got %h", exp, got);
      errors++;
    end
  endtask

  task automatic check_rtrn(input string name, input missunit_pkg::port_vec_t exp, got);
    if (got !== exp) begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_tid(input missunit_pkg::tid_t exp, got);
    if (got !== exp) begin
      $display("** Error: miss_rtrn_id_o expected %h got %h", exp, got);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, got);
    if (got !== exp) begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "failed");
  endtask

  //////////////////////////////////////////////////
  // port and memory side helpers
  task automatic raise_miss(input int port, input missunit_pkg::miss_req_t m);
    @(posedge clk_i);
    miss_req_i[port]   <= m;
    miss_valid_i[port] <= 1'b1;
  endtask

  task automatic wait_mem_valid(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < WaitMax && !ok; n++) begin
      @(negedge clk_i);
      ok = mem_valid_o;
    end
    if (!ok) begin
      $display("timeout while waiting for a memory request");
      errors++;
    end
  endtask

  // acks after a random delay, the port drops its request on the ack edge
  task automatic accept_req(input int port, input logic exp_miss);
    int d;
    missunit_pkg::mem_req_t first;
    first = mem_req_o;
    d = $unsigned($random(seed)) % 3;
    repeat (d) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_bit("mem_valid_o", 1'b1, mem_valid_o);
      check_mem_req(first, mem_req_o);
    end
    @(posedge clk_i);
    mem_ack_i <= 1'b1;
    @(negedge clk_i);
    check_rtrn("miss_ack_o", missunit_pkg::port_vec_t'(1) << port, miss_ack_o);
    check_bit("miss_o", exp_miss, miss_o);
    @(posedge clk_i);
    mem_ack_i          <= 1'b0;
    miss_valid_i[port] <= 1'b0;
  endtask

  task automatic send_rtrn(input missunit_pkg::mem_rtrn_e rt, input missunit_pkg::tid_t tid,
                           input missunit_pkg::line_t data, output missunit_pkg::cl_wr_t cw,
                           output missunit_pkg::port_vec_t rv, output missunit_pkg::tid_t rid);
    repeat ($unsigned($random(seed)) % 4) @(posedge clk_i);
    @(posedge clk_i);
    mem_rtrn_vld_i   <= 1'b1;
    mem_rtrn_i.rtype <= rt;
    mem_rtrn_i.tid   <= tid;
    mem_rtrn_i.data  <= data;
    @(negedge clk_i);
    cw  = cl_wr_o;
    rv  = miss_rtrn_vld_o;
    rid = miss_rtrn_id_o;
    @(posedge clk_i);
    mem_rtrn_vld_i <= 1'b0;
  endtask

  function automatic missunit_pkg::line_t rand_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  //////////////////////////////////////////////////
  // sequence of tests
  initial begin : p_main
    missunit_pkg::miss_req_t  m, m2;
    missunit_pkg::mem_req_t   exp_req;
    missunit_pkg::cl_wr_t     exp_cl, cw;
    missunit_pkg::port_vec_t  rv;
    missunit_pkg::tid_t       rid;
    missunit_pkg::line_t      rdata;
    bit                       ok;
    bit                       seen [64];
    int                       cnt, acks, ack_at, start;

    seed            = 32'h087e42f3;
    errors          = 0;
    tests           = 0;
    rst_ni          = 1'b0;
    enable_i        = 1'b0;
    flush_i         = 1'b0;
    wbuffer_empty_i = 1'b1;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_i      = '0;
    miss_req_i      = '0;
    miss_valid_i    = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // reset sweep
    start = errors;
    cnt   = 0;
    foreach (seen[k]) seen[k] = 1'b0;
    for (int n = 0; n < SweepMax; n++) begin
      @(negedge clk_i);
      check_bit("mem_valid_o", 1'b0, mem_valid_o);
      check_bit("cache_en_o", 1'b0, cache_en_o);
      if (!cl_wr_o.vld) break;
      if (cl_wr_o.we !== '1 || cl_wr_o.vld_bits !== '0 || seen[cl_wr_o.idx]) begin
        $display("reset sweep wrote index %0d twice or not as all ways invalid", cl_wr_o.idx);
        errors++;
      end
      seen[cl_wr_o.idx] = 1'b1;
      cnt++;
    end
    if (cnt != 64) begin
      $display("reset sweep covered %0d indexes instead of 64", cnt);
      errors++;
    end
    close_test("reset sweep", start);

    // cached read
    start = errors;
    m = '{paddr: $random(seed), we: 1'b0, nc: 1'b0, size: 3'd3, id: 2'd1,
          wdata: {$random(seed), $random(seed)}, vld_bits: 4'b0011};
    rdata = rand_line();
    ref_refill(m, rdata, exp_req, exp_cl);
    raise_miss(0, m);
    wait_mem_valid(ok);
    if (ok) begin
      check_mem_req(exp_req, mem_req_o);
      accept_req(0, 1'b1);
      send_rtrn(missunit_pkg::LOAD_ACK, m.id, rdata, cw, rv, rid);
      check_cl_wr(exp_cl, cw);
      check_rtrn("miss_rtrn_vld_o", 3'b001, rv);
    end
    close_test("cached read", start);

    // nc read
    start = errors;
    m = '{paddr: $random(seed), we: 1'b0, nc: 1'b1, size: 3'd2, id: 2'd3,
          wdata: '0, vld_bits: 4'b0000};
    rdata = rand_line();
    ref_refill(m, rdata, exp_req, exp_cl);
    raise_miss(1, m);
    wait_mem_valid(ok);
    if (ok) begin
      check_mem_req(exp_req, mem_req_o);
      accept_req(1, 1'b0);
      send_rtrn(missunit_pkg::LOAD_ACK, m.id, rdata, cw, rv, rid);
      check_cl_wr(exp_cl, cw);
      check_rtrn("miss_rtrn_vld_o", 3'b010, rv);
    end
    close_test("nc read", start);

    // store on the write port
    start = errors;
    m = '{paddr: $random(seed), we: 1'b1, nc: 1'b0, size: 3'd2, id: 2'd2,
          wdata: {$random(seed), $random(seed)}, vld_bits: 4'b0000};
    ref_refill(m, '0, exp_req, exp_cl);
    raise_miss(`MU_NUM_PORTS - 1, m);
    wait_mem_valid(ok);
    if (ok) begin
      check_mem_req(exp_req, mem_req_o);
      accept_req(`MU_NUM_PORTS - 1, 1'b0);
      send_rtrn(missunit_pkg::STORE_ACK, m.id, '0, cw, rv, rid);
      check_rtrn("miss_rtrn_vld_o", 3'b100, rv);
      check_tid(m.id, rid);
    end
    close_test("store", start);

    // second read to the MSHR line
    start = errors;
    m = '{paddr: $random(seed), we: 1'b0, nc: 1'b0, size: 3'd3, id: 2'd0,
          wdata: '0, vld_bits: 4'b1110};
    m2       = m;
    m2.paddr = m.paddr ^ 32'h8;
    m2.id    = 2'd1;
    raise_miss(0, m);
    wait_mem_valid(ok);
    if (ok) begin
      accept_req(0, 1'b1);
      raise_miss(1, m2);
      repeat (3) begin
        @(negedge clk_i);
        check_bit("mem_valid_o", 1'b0, mem_valid_o);
        @(posedge clk_i);
      end
      send_rtrn(missunit_pkg::LOAD_ACK, m.id, rand_line(), cw, rv, rid);
      check_rtrn("miss_rtrn_vld_o", 3'b001, rv);
      ok = 1'b0;
      for (int n = 0; n < WaitMax && !ok; n++) begin
        @(negedge clk_i);
        if (mem_valid_o) begin
          $display("read to the MSHR line was sent to memory");
          errors++;
        end
        ok = |miss_replay_o;
      end
      if (ok) begin
        check_rtrn("miss_replay_o", 3'b010, miss_replay_o);
      end else begin
        $display("timeout while waiting for the replay");
        errors++;
      end
      @(posedge clk_i);
      miss_valid_i[1] <= 1'b0;
    end
    close_test("replay", start);

    // flush with enable
    start  = errors;
    cnt    = 0;
    acks   = 0;
    ack_at = 0;
    @(posedge clk_i);
    enable_i <= 1'b1;
    flush_i  <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    for (int n = 0; n < SweepMax; n++) begin
      @(negedge clk_i);
      if (cl_wr_o.vld && cl_wr_o.we === '1) begin
        cnt++;
      end else if (cnt > 0) begin
        break;
      end
      if (flush_ack_o) begin
        acks++;
        ack_at = cnt;
      end
    end
    if (cnt != 64 || acks != 1 || ack_at != 64) begin
      $display("flush swept %0d indexes with %0d acks, last ack at index count %0d",
               cnt, acks, ack_at);
      errors++;
    end
    check_bit("cache_en_o", 1'b1, cache_en_o);
    close_test("flush", start);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/missunit_pkg.sv
design/miss_port_arbiter.sv
design/refill_way_select.sv
design/miss_mshr.sv
design/miss_ctrl_fsm.sv
design/refill_write_port.sv
design/dcache_missunit.sv
test/tb_dcache_missunit.sv

// File: Bender.yml
package:
  name: dcache_missunit

sources:
  - include_dirs:
      - design
    files:
      - design/missunit_pkg.sv
      - design/miss_port_arbiter.sv
      - design/refill_way_select.sv
      - design/miss_mshr.sv
      - design/miss_ctrl_fsm.sv
      - design/refill_write_port.sv
      - design/dcache_missunit.sv
  - target: test
    files:
      - test/tb_dcache_missunit.sv
